// ==== mcu_trace_buffer.f ====
+incdir+verif
src/mcu_trace_pkg.sv
src/trace_store.sv
src/trace_csr.sv
src/mcu_trace_buffer.sv
verif/mcu_trace_buffer_tb.sv

// ==== src/mcu_trace_buffer.sv ====
// MCU debug trace buffer top, joining the packet store and the register block
`timescale 1ns/100ps

module mcu_trace_buffer (
    input  logic                                      clk,
    input  logic                                      rst_b,

    // Single debug enable for capture and access
    input  logic                                      debug_en,

    // Core retire trace
    input  mcu_trace_pkg::trace_port_t                trace,

    // Register bus
    input  mcu_trace_pkg::bus_req_t                   bus_req,
    output mcu_trace_pkg::bus_rsp_t                   bus_rsp,

    // Debug module access
    input  logic                                      dmi_reg_wen,
    input  logic [mcu_trace_pkg::DMI_ADDR_WIDTH-1:0]  dmi_reg_addr,
    input  logic [31:0]                               dmi_reg_wdata,
    output mcu_trace_pkg::dmi_trace_regs_t            dmi_reg
);

    // Pointers in dwords
    logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] rd_ptr;
    logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] wr_ptr;

    // Store status and addressed dword
    logic        valid_data;
    logic        wrapped;
    logic [31:0] rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Packet store
    ////////////////////////////////////////////////////////////////////////////

    trace_store u_store (
        .clk        (clk),
        .rst_b      (rst_b),
        .debug_en   (debug_en),
        .trace      (trace),
        .rd_ptr     (rd_ptr),
        .rd_data    (rd_data),
        .wr_ptr     (wr_ptr),
        .valid_data (valid_data),
        .wrapped    (wrapped)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Register block
    ////////////////////////////////////////////////////////////////////////////

    trace_csr u_csr (
        .clk           (clk),
        .rst_b         (rst_b),
        .debug_en      (debug_en),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .dmi_reg_wen   (dmi_reg_wen),
        .dmi_reg_addr  (dmi_reg_addr),
        .dmi_reg_wdata (dmi_reg_wdata),
        .dmi_reg       (dmi_reg),
        .wr_ptr        (wr_ptr),
        .valid_data    (valid_data),
        .wrapped       (wrapped),
        .rd_data       (rd_data),
        .rd_ptr        (rd_ptr)
    );

endmodule

// ==== src/mcu_trace_pkg.sv ====
// MCU trace buffer shared types, register map and buffer sizing

package mcu_trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Buffer sizing
    ////////////////////////////////////////////////////////////////////////////

    // Packets held in the circular store
    localparam int TRACE_NUM_ENTRIES = 64;
    // Dwords per captured packet
    localparam int TRACE_PACKET_DWORDS = 4;
    // Depth in dwords, reported through CONFIG
    localparam int TRACE_DEPTH_DWORDS = TRACE_NUM_ENTRIES * TRACE_PACKET_DWORDS;

    // Packet index and dword select widths
    localparam int TRACE_ENTRY_IDX_WIDTH = $clog2(TRACE_NUM_ENTRIES);
    localparam int TRACE_WORD_SEL_WIDTH = $clog2(TRACE_PACKET_DWORDS);
    // Dword pointer, packet index on top of dword select
    localparam int TRACE_PTR_WIDTH = TRACE_ENTRY_IDX_WIDTH + TRACE_WORD_SEL_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////////////////////

    localparam int REG_ADDR_WIDTH = 5;

    localparam logic [REG_ADDR_WIDTH-1:0] REG_STATUS = 5'h00;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_CONFIG = 5'h04;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_DATA   = 5'h08;
    localparam logic [REG_ADDR_WIDTH-1:0] REG_WR_PTR = 5'h0C;
    // Only writable register
    localparam logic [REG_ADDR_WIDTH-1:0] REG_RD_PTR = 5'h10;

    // DMI side address of the read pointer
    localparam int DMI_ADDR_WIDTH = 7;
    localparam logic [DMI_ADDR_WIDTH-1:0] DMI_TRACE_RD_PTR_ADDR = 7'h5D;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Stored packet, dword 0 in the low bits
    typedef struct packed {
        logic [24:0] reserved;   // dword 3, bits 31:7
        logic        interrupt;  // dword 3, bit 6
        logic [4:0]  ecause;     // dword 3, bits 5:1
        logic        exception;  // dword 3, bit 0
        logic [31:0] tval;       // dword 2
        logic [31:0] address;    // dword 1
        logic [31:0] insn;       // dword 0
    } trace_packet_t;

    // Retire trace port of the core
    typedef struct packed {
        logic        valid;
        logic [31:0] insn;
        logic [31:0] address;
        logic        exception;
        logic [4:0]  ecause;
        logic        interrupt;
        logic [31:0] tval;
    } trace_port_t;

    // Register bus request, single cycle strobe
    typedef struct packed {
        logic                      req;
        logic                      write;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [31:0]               wdata;
        logic [3:0]                wstrb;
    } bus_req_t;

    // Register bus response, one cycle after the request
    typedef struct packed {
        logic        rsp_valid;
        logic [31:0] rdata;
        logic        error;
    } bus_rsp_t;

    // Register mirror seen by the debug module
    typedef struct packed {
        logic [31:0] trace_status;
        logic [31:0] trace_config;
        logic [31:0] trace_wr_ptr;
        logic [31:0] trace_rd_ptr;
        logic [31:0] trace_data;
    } dmi_trace_regs_t;

endpackage

// ==== src/trace_csr.sv ====
// Trace buffer register block for the host bus and the debug module mirror
`timescale 1ns/100ps

module trace_csr (
    input  logic                                      clk,
    input  logic                                      rst_b,

    // Gates bus access and the DMI mirror
    input  logic                                      debug_en,

    // Register bus
    input  mcu_trace_pkg::bus_req_t                   bus_req,
    output mcu_trace_pkg::bus_rsp_t                   bus_rsp,

    // Debug module access
    input  logic                                      dmi_reg_wen,
    input  logic [mcu_trace_pkg::DMI_ADDR_WIDTH-1:0]  dmi_reg_addr,
    input  logic [31:0]                               dmi_reg_wdata,
    output mcu_trace_pkg::dmi_trace_regs_t            dmi_reg,

    // Store status and read data
    input  logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] wr_ptr,
    input  logic                                      valid_data,
    input  logic                                      wrapped,
    input  logic [31:0]                               rd_data,

    // Read pointer toward the store
    output logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] rd_ptr
);

    // Register words, shared by the bus read mux and the DMI mirror
    logic [31:0] status_word;
    logic [31:0] config_word;
    logic [31:0] wr_ptr_word;
    logic [31:0] rd_ptr_word;
    logic [31:0] data_word;

    // Bus decode
    logic        bus_acc;
    logic        reg_hit;
    logic [31:0] reg_rdata;
    logic        access_err;

    // Read pointer update
    logic        rd_ptr_bus_wr;
    logic        rd_ptr_dmi_wr;
    logic [31:0] wr_mask;
    logic [31:0] rd_ptr_merged;

    // Response registers
    logic        rsp_valid_q;
    logic        rsp_error_q;
    logic [31:0] rsp_rdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // Register words
    ////////////////////////////////////////////////////////////////////////////

    assign status_word = {30'b0, wrapped, valid_data};
    assign config_word = 32'(mcu_trace_pkg::TRACE_DEPTH_DWORDS);
    assign wr_ptr_word = 32'(wr_ptr);
    assign rd_ptr_word = 32'(rd_ptr);
    // Dword addressed by the read pointer
    assign data_word   = rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Bus decode
    ////////////////////////////////////////////////////////////////////////////

    // Requests only reach the registers in debug mode
    assign bus_acc = bus_req.req && debug_en;

    // Read mux, anything off the map is a miss
    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (bus_req.addr)
            mcu_trace_pkg::REG_STATUS: reg_rdata = status_word;
            mcu_trace_pkg::REG_CONFIG: reg_rdata = config_word;
            mcu_trace_pkg::REG_DATA:   reg_rdata = data_word;
            mcu_trace_pkg::REG_WR_PTR: reg_rdata = wr_ptr_word;
            mcu_trace_pkg::REG_RD_PTR: reg_rdata = rd_ptr_word;
            default:                   reg_hit   = 1'b0;
        endcase
    end

    // Debug off, unmapped offset, or write to a read-only register
    assign access_err = !debug_en || !reg_hit ||
                        (bus_req.write && (bus_req.addr != mcu_trace_pkg::REG_RD_PTR));

    ////////////////////////////////////////////////////////////////////////////
    // Read pointer
    ////////////////////////////////////////////////////////////////////////////

    assign rd_ptr_bus_wr = bus_acc && bus_req.write &&
                           (bus_req.addr == mcu_trace_pkg::REG_RD_PTR);

    assign rd_ptr_dmi_wr = dmi_reg_wen && debug_en &&
                           (dmi_reg_addr == mcu_trace_pkg::DMI_TRACE_RD_PTR_ADDR);

    // Byte strobes expanded to a bit mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wr_mask[8*b +: 8] = {8{bus_req.wstrb[b]}};
        end
    end

    // Unstrobed bytes keep their current value
    assign rd_ptr_merged = (rd_ptr_word & ~wr_mask) | (bus_req.wdata & wr_mask);

    // Bus write beats a DMI write in the same cycle
    // Only the low pointer bits are kept, so values wrap modulo the depth
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_ptr <= '0;
        end else if (rd_ptr_bus_wr) begin
            rd_ptr <= rd_ptr_merged[mcu_trace_pkg::TRACE_PTR_WIDTH-1:0];
        end else if (rd_ptr_dmi_wr) begin
            rd_ptr <= dmi_reg_wdata[mcu_trace_pkg::TRACE_PTR_WIDTH-1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus response
    ////////////////////////////////////////////////////////////////////////////

    // Valid and error pulse one cycle after each request
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rsp_valid_q <= 1'b0;
            rsp_error_q <= 1'b0;
        end else begin
            rsp_valid_q <= bus_req.req;
            rsp_error_q <= bus_req.req && access_err;
        end
    end

    // Read data, zero for writes and for requests outside debug mode
    always_ff @(posedge clk) begin
        if (bus_acc && !bus_req.write) begin
            rsp_rdata_q <= reg_rdata;
        end else begin
            rsp_rdata_q <= '0;
        end
    end

    assign bus_rsp.rsp_valid = rsp_valid_q;
    assign bus_rsp.rdata     = rsp_rdata_q;
    assign bus_rsp.error     = rsp_error_q;

    ////////////////////////////////////////////////////////////////////////////
    // DMI mirror
    ////////////////////////////////////////////////////////////////////////////

    // Whole mirror reads zero outside debug mode
    always_comb begin
        dmi_reg = '0;
        if (debug_en) begin
            dmi_reg.trace_status = status_word;
            dmi_reg.trace_config = config_word;
            dmi_reg.trace_wr_ptr = wr_ptr_word;
            dmi_reg.trace_rd_ptr = rd_ptr_word;
            dmi_reg.trace_data   = data_word;
        end
    end

endmodule

// ==== src/trace_store.sv ====
// Circular trace packet store with sticky status flags and a dword read port
`timescale 1ns/100ps

module trace_store (
    input  logic                                    clk,
    input  logic                                    rst_b,

    // Capture qualifier
    input  logic                                    debug_en,

    // Core retire trace
    input  mcu_trace_pkg::trace_port_t              trace,

    // Dword read port
    input  logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] rd_ptr,
    output logic [31:0]                             rd_data,

    // Status toward the register block
    output logic [mcu_trace_pkg::TRACE_PTR_WIDTH-1:0] wr_ptr,
    output logic                                    valid_data,
    output logic                                    wrapped
);

    mcu_trace_pkg::trace_packet_t mem [mcu_trace_pkg::TRACE_NUM_ENTRIES];
    mcu_trace_pkg::trace_packet_t wr_packet;
    mcu_trace_pkg::trace_packet_t rd_packet;

    logic                                              wr_en;
    logic [mcu_trace_pkg::TRACE_ENTRY_IDX_WIDTH-1:0]   wr_idx;
    logic [mcu_trace_pkg::TRACE_ENTRY_IDX_WIDTH-1:0]   rd_idx;
    logic [mcu_trace_pkg::TRACE_WORD_SEL_WIDTH-1:0]    rd_word;

    ////////////////////////////////////////////////////////////////////////////
    // Capture
    ////////////////////////////////////////////////////////////////////////////

    // No back-pressure, every qualified retire is taken
    assign wr_en = trace.valid && debug_en;

    // Pack trace fields into the stored layout
    assign wr_packet.reserved  = '0;
    assign wr_packet.interrupt = trace.interrupt;
    assign wr_packet.ecause    = trace.ecause;
    assign wr_packet.exception = trace.exception;
    assign wr_packet.tval      = trace.tval;
    assign wr_packet.address   = trace.address;
    assign wr_packet.insn      = trace.insn;

    // Write pointer and sticky flags
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_idx     <= '0;
            valid_data <= 1'b0;
            wrapped    <= 1'b0;
        end else if (wr_en) begin
            valid_data <= 1'b1;
            // Last entry rolls back to zero and marks the wrap
            if (wr_idx == mcu_trace_pkg::TRACE_ENTRY_IDX_WIDTH'(
                    mcu_trace_pkg::TRACE_NUM_ENTRIES - 1)) begin
                wr_idx  <= '0;
                wrapped <= 1'b1;
            end else begin
                wr_idx <= wr_idx + 1'b1;
            end
        end
    end

    // Packet array, cleared on reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < mcu_trace_pkg::TRACE_NUM_ENTRIES; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_idx] <= wr_packet;
        end
    end

    // Dword view of the write pointer, packet index times four
    assign wr_ptr = {wr_idx, {mcu_trace_pkg::TRACE_WORD_SEL_WIDTH{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // Read port
    ////////////////////////////////////////////////////////////////////////////

    // Upper bits pick the packet, low bits pick the dword
    assign rd_idx  = rd_ptr[mcu_trace_pkg::TRACE_PTR_WIDTH-1:
                            mcu_trace_pkg::TRACE_WORD_SEL_WIDTH];
    assign rd_word = rd_ptr[mcu_trace_pkg::TRACE_WORD_SEL_WIDTH-1:0];

    assign rd_packet = mem[rd_idx];

    // Combinational so a capture is readable on the next sampling edge
    assign rd_data = rd_packet[rd_word*32 +: 32];

endmodule

// ==== verif/mcu_trace_buffer_tests.svh ====
// Trace buffer stimulus, model updates and bus and DMI access tasks

// Xorshift random source
function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Packet index in the upper bits and dword in the low two
function automatic logic [31:0] model_dword(input logic [7:0] ptr);
    return model_mem[ptr[7:2]][ptr[1:0]];
endfunction

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
        $display("ERR %s expected 0x%08h actual 0x%08h", name, exp, act);
        errors++;
    end
endtask

task automatic wait_response(input string name);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!bus_rsp.rsp_valid && cycles < 16) begin
        @(negedge clk);
        cycles++;
    end
    if (!bus_rsp.rsp_valid) begin
        $display("Timeout waiting for a bus response in %s", name);
        errors++;
    end
endtask

task automatic bus_access(input string name, input logic is_write, input logic [4:0] addr,
                          input logic [31:0] wdata, input logic [3:0] wstrb,
                          output logic [31:0] rdata, output logic err);
    @(posedge clk);
    bus_req <= '{req: 1'b1, write: is_write, addr: addr, wdata: wdata, wstrb: wstrb};
    @(posedge clk);
    bus_req.req <= 1'b0;
    wait_response(name);
    rdata = bus_rsp.rdata;
    err   = bus_rsp.error;
endtask

task automatic bus_read(input string name, input logic [4:0] addr,
                        input logic [31:0] exp_data, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(name, 1'b0, addr, '0, 4'h0, rdata, err);
    check_value({name, " data"}, exp_data, rdata);
    check_value({name, " error"}, 32'(exp_err), 32'(err));
endtask

task automatic bus_write(input string name, input logic [4:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    bus_access(name, 1'b1, addr, wdata, wstrb, rdata, err);
    check_value({name, " error"}, 32'(exp_err), 32'(err));
    // Only byte 0 of the pointer exists
    if (addr == mcu_trace_pkg::REG_RD_PTR && !exp_err && wstrb[0]) begin
        model_rd_ptr = wdata[7:0];
    end
endtask

// Back-to-back retires with the model following the sampled enable
task automatic capture_burst(input int count);
    logic [31:0] r_insn;
    logic [31:0] r_addr;
    logic [31:0] r_tval;
    logic [31:0] r_flags;
    for (int i = 0; i < count; i++) begin
        r_insn  = next_random();
        r_addr  = next_random();
        r_tval  = next_random();
        r_flags = next_random();
        @(posedge clk);
        trace <= '{valid: 1'b1, insn: r_insn, address: r_addr, exception: r_flags[0],
                   ecause: r_flags[5:1], interrupt: r_flags[6], tval: r_tval};
        if (debug_en) begin
            model_mem[model_wr][0] = r_insn;
            model_mem[model_wr][1] = r_addr;
            model_mem[model_wr][2] = r_tval;
            model_mem[model_wr][3] = {25'b0, r_flags[6:0]};
            model_valid = 1'b1;
            if (model_wr == 63) begin
                model_wr      = 0;
                model_wrapped = 1'b1;
            end else begin
                model_wr++;
            end
        end
    end
    @(posedge clk);
    trace.valid <= 1'b0;
endtask

task automatic read_entries(input string name, input int count);
    for (int p = 0; p < count; p++) begin
        bus_write($sformatf("%s RD_PTR %0d", name, p), mcu_trace_pkg::REG_RD_PTR, 32'(p),
                  4'hF, 1'b0);
        bus_read($sformatf("%s DATA %0d", name, p), mcu_trace_pkg::REG_DATA,
                 model_dword(8'(p)), 1'b0);
    end
endtask

task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata);
    @(posedge clk);
    dmi_reg_wen   <= 1'b1;
    dmi_reg_addr  <= addr;
    dmi_reg_wdata <= wdata;
    @(posedge clk);
    dmi_reg_wen <= 1'b0;
    @(negedge clk);
endtask

// Status word first and data word last
task automatic check_mirror(input string name);
    logic [4:0][31:0] exp_words;
    logic [4:0][31:0] act_words;
    exp_words[4] = {30'b0, model_wrapped, model_valid};
    exp_words[3] = 32'd256;
    exp_words[2] = 32'(model_wr * 4);
    exp_words[1] = 32'(model_rd_ptr);
    exp_words[0] = model_dword(model_rd_ptr);
    if (!debug_en) begin
        exp_words = '0;
    end
    act_words = dmi_reg;
    for (int w = 4; w >= 0; w--) begin
        check_value($sformatf("%s mirror word %0d", name, 4 - w), exp_words[w], act_words[w]);
    end
endtask

task automatic reset_state_test();
    // Response stays idle until the first request
    repeat (3) begin
        @(negedge clk);
        check_value("reset rsp_valid", 32'd0, 32'(bus_rsp.rsp_valid));
        check_value("reset error", 32'd0, 32'(bus_rsp.error));
        check_value("reset rdata", 32'd0, bus_rsp.rdata);
    end
    bus_read("reset STATUS", mcu_trace_pkg::REG_STATUS, 32'd0, 1'b0);
    bus_read("reset WR_PTR", mcu_trace_pkg::REG_WR_PTR, 32'd0, 1'b0);
    bus_read("reset RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'd0, 1'b0);
    bus_read("reset CONFIG", mcu_trace_pkg::REG_CONFIG, 32'd256, 1'b0);
    bus_read("reset DATA", mcu_trace_pkg::REG_DATA, 32'd0, 1'b0);
endtask

task automatic capture_test();
    capture_burst(10);
    read_entries("capture", 40);
    bus_read("capture WR_PTR", mcu_trace_pkg::REG_WR_PTR, 32'd40, 1'b0);
    bus_read("capture STATUS", mcu_trace_pkg::REG_STATUS, 32'd1, 1'b0);
endtask

// 70 packets in total so entries 0 to 5 are overwritten
task automatic wrap_test();
    capture_burst(60);
    bus_read("wrap STATUS", mcu_trace_pkg::REG_STATUS, 32'd3, 1'b0);
    bus_read("wrap WR_PTR", mcu_trace_pkg::REG_WR_PTR, 32'd24, 1'b0);
    read_entries("wrap", 28);
endtask

task automatic gating_test();
    @(posedge clk);
    debug_en <= 1'b0;
    capture_burst(3);
    @(negedge clk);
    check_mirror("gated");
    bus_read("gated STATUS", mcu_trace_pkg::REG_STATUS, 32'd0, 1'b1);
    bus_read("gated DATA", mcu_trace_pkg::REG_DATA, 32'd0, 1'b1);
    bus_write("gated RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'h77, 4'hF, 1'b1);
    @(posedge clk);
    debug_en <= 1'b1;
    bus_read("ungated WR_PTR", mcu_trace_pkg::REG_WR_PTR, 32'd24, 1'b0);
    bus_read("ungated RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'(model_rd_ptr), 1'b0);
endtask

task automatic access_error_test();
    // Read-only registers
    for (int a = 0; a < 16; a += 4) begin
        bus_write($sformatf("ro write 0x%02h", a), 5'(a), 32'hFFFF_FFFF, 4'hF, 1'b1);
    end
    // Off the register map
    for (int a = 20; a < 32; a += 4) begin
        bus_read($sformatf("unmapped read 0x%02h", a), 5'(a), 32'd0, 1'b1);
        bus_write($sformatf("unmapped write 0x%02h", a), 5'(a), 32'hFF, 4'hF, 1'b1);
    end
    bus_read("after errors STATUS", mcu_trace_pkg::REG_STATUS,
             {30'b0, model_wrapped, model_valid}, 1'b0);
    bus_read("after errors WR_PTR", mcu_trace_pkg::REG_WR_PTR, 32'(model_wr * 4), 1'b0);
    bus_read("after errors RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'(model_rd_ptr), 1'b0);
    // Only the low byte may move under byte strobes
    bus_write("strobe setup", mcu_trace_pkg::REG_RD_PTR, 32'h13, 4'hF, 1'b0);
    bus_write("strobe upper", mcu_trace_pkg::REG_RD_PTR, 32'hFFFF_FF00, 4'b1110, 1'b0);
    bus_read("strobe upper RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'h13, 1'b0);
    bus_write("strobe low", mcu_trace_pkg::REG_RD_PTR, 32'hA5A5_A55A, 4'b0001, 1'b0);
    bus_read("strobe low RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'h5A, 1'b0);
endtask

task automatic dmi_test();
    // 0x123 wraps to 0x23
    dmi_write(mcu_trace_pkg::DMI_TRACE_RD_PTR_ADDR, 32'h123);
    model_rd_ptr = 8'h23;
    check_mirror("dmi load");
    bus_read("dmi RD_PTR", mcu_trace_pkg::REG_RD_PTR, 32'h23, 1'b0);
    dmi_write(7'h5C, 32'h40);
    check_mirror("dmi other address");
    // Bus and DMI hit the pointer in the same cycle
    @(posedge clk);
    bus_req <= '{req: 1'b1, write: 1'b1, addr: mcu_trace_pkg::REG_RD_PTR,
                 wdata: 32'h11, wstrb: 4'hF};
    dmi_reg_wen   <= 1'b1;
    dmi_reg_addr  <= mcu_trace_pkg::DMI_TRACE_RD_PTR_ADDR;
    dmi_reg_wdata <= 32'h22;
    @(posedge clk);
    bus_req.req <= 1'b0;
    dmi_reg_wen <= 1'b0;
    wait_response("collision");
    model_rd_ptr = 8'h11;
    check_mirror("collision");
endtask

// ==== verif/mcu_trace_buffer_tb.sv ====
// Testbench for the MCU debug trace buffer, checked against a packet reference model
`timescale 1ns/100ps

module mcu_trace_buffer_tb;

    logic                           clk;
    logic                           rst_b;
    logic                           debug_en;
    mcu_trace_pkg::trace_port_t     trace;
    mcu_trace_pkg::bus_req_t        bus_req;
    mcu_trace_pkg::bus_rsp_t        bus_rsp;
    logic                           dmi_reg_wen;
    logic [6:0]                     dmi_reg_addr;
    logic [31:0]                    dmi_reg_wdata;
    mcu_trace_pkg::dmi_trace_regs_t dmi_reg;

    // Reference model, four dwords per packet
    logic [31:0] model_mem [64][4];
    int          model_wr;
    logic        model_valid;
    logic        model_wrapped;
    logic [7:0]  model_rd_ptr;

    int          errors;
    logic [31:0] rng_state;

    mcu_trace_buffer dut0 (
        .clk           (clk),
        .rst_b         (rst_b),
        .debug_en      (debug_en),
        .trace         (trace),
        .bus_req       (bus_req),
        .bus_rsp       (bus_rsp),
        .dmi_reg_wen   (dmi_reg_wen),
        .dmi_reg_addr  (dmi_reg_addr),
        .dmi_reg_wdata (dmi_reg_wdata),
        .dmi_reg       (dmi_reg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Response timing
    ////////////////////////////////////////////////////////////////////////////

    // One response pulse per request, exactly one cycle later
    rsp_follows_req: assert property (@(posedge clk) disable iff (!rst_b)
        bus_req.req |=> bus_rsp.rsp_valid)
        else begin
            $display("Bus response valid did not follow a request by one cycle");
            errors++;
        end

    no_stray_rsp: assert property (@(posedge clk) disable iff (!rst_b)
        !bus_req.req |=> !bus_rsp.rsp_valid)
        else begin
            $display("Bus response valid seen without a request one cycle before");
            errors++;
        end

    `include "mcu_trace_buffer_tests.svh"

    initial begin
        rst_b         = 1'b0;
        debug_en      = 1'b0;
        trace         = '0;
        bus_req       = '0;
        dmi_reg_wen   = 1'b0;
        dmi_reg_addr  = '0;
        dmi_reg_wdata = '0;
        errors        = 0;
        rng_state     = 32'd1808;
        // Model mirrors the cleared store
        for (int i = 0; i < 64; i++) begin
            for (int w = 0; w < 4; w++) begin
                model_mem[i][w] = '0;
            end
        end
        model_wr      = 0;
        model_valid   = 1'b0;
        model_wrapped = 1'b0;
        model_rd_ptr  = '0;

        repeat (8) @(posedge clk);
        rst_b    <= 1'b1;
        debug_en <= 1'b1;

        reset_state_test();
        capture_test();
        wrap_test();
        gating_test();
        access_error_test();
        dmi_test();

        repeat (2) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
